//--- source/enc_ctrl_pkg.sv
/*
  shared definitions of the encoder pipeline controller
  - ctu index widths and the smallest supported frame
  - ctu position and frame command types
  - coding mode and pipeline phase enums
  - stage enable, engine start/done and fetch request structs
*/
package enc_ctrl_pkg;

  localparam int CTU_X_W        = 7;
  localparam int CTU_Y_W        = 6;
  localparam int MIN_FRAME_CTUS = 6;

  typedef logic [CTU_X_W-1:0] ctu_x_t;
  typedef logic [CTU_Y_W-1:0] ctu_y_t;

  typedef enum logic [0:0] {
    MODE_INTRA = 1'b0,
    MODE_INTER = 1'b1
  } enc_mode_e;

  // fill, steady state and drain of the six-beat pipeline
  typedef enum logic [3:0] {
    IDLE, FILL0, FILL1, FILL2, FILL3, FILL4,
    STEADY, DRAIN0, DRAIN1, DRAIN2, DRAIN3, DRAIN4
  } pipe_phase_e;

  typedef struct packed {
    ctu_x_t x;
    ctu_y_t y;
  } ctu_pos_t;

  typedef struct packed {
    enc_mode_e mode;
    ctu_x_t    last_x;
    ctu_y_t    last_y;
  } frame_cfg_t;

  typedef struct packed {
    logic load; logic s1; logic s2; logic rec; logic db; logic ec;
  } stage_ena_t;

  typedef struct packed {
    logic prei; logic posi; logic ime; logic fme; logic rec; logic db; logic ec;
  } eng_start_t;

  typedef struct packed {
    logic fetch; logic prei; logic posi; logic ime;
    logic fme;   logic rec;  logic db;   logic ec;
  } eng_done_t;

  typedef struct packed {
    logic     en;
    logic     with_ref;
    ctu_pos_t pos;
  } fetch_req_t;

  typedef struct packed {
    fetch_req_t cur_luma;
    fetch_req_t cur_chroma;
    fetch_req_t db_load;
    fetch_req_t db_store;
  } fetch_bus_t;

endpackage

//--- source/enc_frame_cfg.sv
/*
  frame command register
  - valid/ready acceptance while the pipeline is idle
  - holds mode and frame size for the whole frame
*/
module enc_frame_cfg import enc_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  logic       frame_valid_i,
  input  frame_cfg_t frame_cfg_i,
  input  logic       idle_i,
  output logic       frame_ready_o,
  output frame_cfg_t cfg_o
);

  logic accept;

  // new commands only between frames
  assign frame_ready_o = idle_i;
  assign accept        = frame_valid_i & idle_i;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cfg_o <= '0;
    end else if (accept) begin
      cfg_o <= frame_cfg_i;
    end
  end

  // ------------------------------------------------------------------------
  // the fill sequence needs at least MIN_FRAME_CTUS ctus per frame
  // ------------------------------------------------------------------------
  a_min_frame : assert property (
    @(posedge clk) disable iff (!rstn)
    accept |-> ((int'(frame_cfg_i.last_x) + 1) * (int'(frame_cfg_i.last_y) + 1)
                >= MIN_FRAME_CTUS)
  );

endmodule

//--- source/pipe_phase_fsm.sv
/*
  pipeline phase FSM
  - fill, steady and drain sequencing, one phase step per beat
  - stage enable table and beat trigger
  - frame done pulse on the last beat
*/
module pipe_phase_fsm import enc_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic        accept_i,
  input  logic        beat_done_i,
  input  logic        last_loaded_i,
  output pipe_phase_e phase_o,
  output stage_ena_t  stage_ena_o,
  output logic        beat_go_o,
  output logic        idle_o,
  output logic        frame_done_o
);

  pipe_phase_e phase_nxt;
  logic        go_nxt;

  assign idle_o       = (phase_o == IDLE);
  assign frame_done_o = (phase_o == DRAIN4) & beat_done_i;

  // every beat except the last one triggers the next
  assign go_nxt = (idle_o & accept_i) | (beat_done_i & (phase_o != DRAIN4));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      phase_o   <= IDLE;
      beat_go_o <= 1'b0;
    end else begin
      phase_o   <= phase_nxt;
      beat_go_o <= go_nxt;
    end
  end

  // ------------------------------------------------------------------------
  // next phase
  // ------------------------------------------------------------------------
  always_comb begin
    phase_nxt = phase_o;
    case (phase_o)
      IDLE:    if (accept_i) phase_nxt = FILL0;
      FILL0:   if (beat_done_i) phase_nxt = FILL1;
      FILL1:   if (beat_done_i) phase_nxt = FILL2;
      FILL2:   if (beat_done_i) phase_nxt = FILL3;
      FILL3:   if (beat_done_i) phase_nxt = FILL4;
      FILL4:   if (beat_done_i) phase_nxt = STEADY;
      // leave once the last ctu went through the load stage
      STEADY:  if (beat_done_i && last_loaded_i) phase_nxt = DRAIN0;
      DRAIN0:  if (beat_done_i) phase_nxt = DRAIN1;
      DRAIN1:  if (beat_done_i) phase_nxt = DRAIN2;
      DRAIN2:  if (beat_done_i) phase_nxt = DRAIN3;
      DRAIN3:  if (beat_done_i) phase_nxt = DRAIN4;
      DRAIN4:  if (beat_done_i) phase_nxt = IDLE;
      default: phase_nxt = IDLE;
    endcase
  end

  // ------------------------------------------------------------------------
  // stage enables, bit order load s1 s2 rec db ec
  // ------------------------------------------------------------------------
  always_comb begin
    case (phase_o)
      FILL0:   stage_ena_o = stage_ena_t'(6'b100000);
      FILL1:   stage_ena_o = stage_ena_t'(6'b110000);
      FILL2:   stage_ena_o = stage_ena_t'(6'b111000);
      FILL3:   stage_ena_o = stage_ena_t'(6'b111100);
      FILL4:   stage_ena_o = stage_ena_t'(6'b111110);
      STEADY:  stage_ena_o = stage_ena_t'(6'b111111);
      DRAIN0:  stage_ena_o = stage_ena_t'(6'b011111);
      DRAIN1:  stage_ena_o = stage_ena_t'(6'b001111);
      DRAIN2:  stage_ena_o = stage_ena_t'(6'b000111);
      DRAIN3:  stage_ena_o = stage_ena_t'(6'b000011);
      DRAIN4:  stage_ena_o = stage_ena_t'(6'b000001);
      default: stage_ena_o = stage_ena_t'(6'b000000);
    endcase
  end

  // a beat is always started inside a frame
  a_no_go_in_idle : assert property (
    @(posedge clk) disable iff (!rstn)
    beat_go_o |-> (phase_o != IDLE)
  );

endmodule

//--- source/done_collector.sv
/*
  engine done collection
  - sticky done flag per engine
  - stage 1 and stage 2 flags combined by coding mode
  - registered beat complete pulse
*/
module done_collector import enc_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  frame_cfg_t cfg_i,
  input  stage_ena_t stage_ena_i,
  input  logic       idle_i,
  input  eng_done_t  done_i,
  output logic       beat_done_o
);

  eng_done_t flags;
  logic      inter;
  logic      s1_flg;
  logic      s2_flg;
  logic      beat_complete;

  assign inter = (cfg_i.mode == MODE_INTER);

  // a done arriving as the beat completes is kept for the next beat
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flags <= '0;
    end else if (idle_i) begin
      flags <= '0;
    end else if (beat_complete) begin
      flags <= done_i;
    end else begin
      flags <= flags | done_i;
    end
  end

  // motion estimation joins the pre-analysis stages in inter frames
  assign s1_flg = inter ? (flags.prei & flags.ime) : flags.prei;
  assign s2_flg = inter ? (flags.posi & flags.fme) : flags.posi;

  assign beat_complete = flags.fetch
                       & (~stage_ena_i.s1  | s1_flg)
                       & (~stage_ena_i.s2  | s2_flg)
                       & (~stage_ena_i.rec | flags.rec)
                       & (~stage_ena_i.db  | flags.db)
                       & (~stage_ena_i.ec  | flags.ec);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_done_o <= 1'b0;
    end else begin
      beat_done_o <= beat_complete & ~idle_i;
    end
  end

  // flags clear as the beat completes, so beats never close back to back
  a_single_done : assert property (
    @(posedge clk) disable iff (!rstn)
    beat_done_o |=> !beat_done_o
  );

endmodule

//--- source/ctu_pos_chain.sv
/*
  ctu position chain
  - raster load counter over the frame
  - per-stage positions shifted once per beat
  - engine start pulses and fetch requests
*/
module ctu_pos_chain import enc_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  frame_cfg_t cfg_i,
  input  stage_ena_t stage_ena_i,
  input  logic       beat_go_i,
  input  logic       idle_i,
  output logic       last_loaded_o,
  output eng_start_t start_o,
  output ctu_pos_t   pos_s1_o,
  output ctu_pos_t   pos_s2_o,
  output ctu_pos_t   pos_rec_o,
  output ctu_pos_t   pos_db_o,
  output ctu_pos_t   pos_ec_o,
  output fetch_bus_t fetch_o
);

  ctu_pos_t   load_cnt;
  ctu_pos_t   pos_load;
  stage_ena_t beat_ena;
  eng_start_t start_nxt;
  logic       inter;

  assign inter = (cfg_i.mode == MODE_INTER);

  assign last_loaded_o = (pos_load.x == cfg_i.last_x) && (pos_load.y == cfg_i.last_y);

  // ------------------------------------------------------------------------
  // raster counter and position shift
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      load_cnt <= '0;
    end else if (idle_i) begin
      load_cnt <= '0;
    end else if (beat_go_i) begin
      if (load_cnt.x == cfg_i.last_x) begin
        load_cnt.x <= '0;
        load_cnt.y <= (load_cnt.y == cfg_i.last_y) ? '0 : load_cnt.y + 1'b1;
      end else begin
        load_cnt.x <= load_cnt.x + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pos_load  <= '0;
      pos_s1_o  <= '0;
      pos_s2_o  <= '0;
      pos_rec_o <= '0;
      pos_db_o  <= '0;
      pos_ec_o  <= '0;
    end else if (beat_go_i) begin
      pos_load  <= load_cnt;
      pos_s1_o  <= pos_load;
      pos_s2_o  <= pos_s1_o;
      pos_rec_o <= pos_s2_o;
      pos_db_o  <= pos_rec_o;
      pos_ec_o  <= pos_db_o;
    end
  end

  // ------------------------------------------------------------------------
  // start pulses, and the stage set of the running beat
  // ------------------------------------------------------------------------
  always_comb begin
    start_nxt.prei = stage_ena_i.s1;
    start_nxt.ime  = stage_ena_i.s1 & inter;
    start_nxt.posi = stage_ena_i.s2;
    start_nxt.fme  = stage_ena_i.s2 & inter;
    start_nxt.rec  = stage_ena_i.rec;
    start_nxt.db   = stage_ena_i.db;
    start_nxt.ec   = stage_ena_i.ec;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      start_o  <= '0;
      beat_ena <= '0;
    end else begin
      start_o <= beat_go_i ? start_nxt : '0;
      if (idle_i) begin
        beat_ena <= '0;
      end else if (beat_go_i) begin
        beat_ena <= stage_ena_i;
      end
    end
  end

  // no top neighbour in row 0, left column output is held back
  always_comb begin
    fetch_o                     = '0;
    fetch_o.cur_luma.en         = beat_ena.load;
    fetch_o.cur_luma.with_ref   = beat_ena.load & inter;
    fetch_o.cur_luma.pos        = pos_load;
    fetch_o.cur_chroma.en       = beat_ena.s2;
    fetch_o.cur_chroma.with_ref = beat_ena.s2 & inter;
    fetch_o.cur_chroma.pos      = pos_s2_o;
    fetch_o.db_load.en          = beat_ena.rec & (pos_rec_o.y != '0);
    fetch_o.db_load.pos         = pos_rec_o;
    fetch_o.db_store.en         = beat_ena.ec & (pos_ec_o.x != '0);
    fetch_o.db_store.pos        = pos_ec_o;
  end

endmodule

//--- source/enc_ctrl_top.sv
/*
  encoder pipeline controller top level
  - frame command register, phase FSM, done collector, position chain
*/
module enc_ctrl_top import enc_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  // frame command
  input  logic       frame_valid_i,
  input  frame_cfg_t frame_cfg_i,
  output logic       frame_ready_o,
  output logic       frame_done_o,
  // engines
  input  eng_done_t  eng_done_i,
  output eng_start_t eng_start_o,
  output ctu_pos_t   pos_s1_o,
  output ctu_pos_t   pos_s2_o,
  output ctu_pos_t   pos_rec_o,
  output ctu_pos_t   pos_db_o,
  output ctu_pos_t   pos_ec_o,
  // fetch unit
  output fetch_bus_t fetch_o
);

  frame_cfg_t cfg;
  stage_ena_t stage_ena;
  logic       accept;
  logic       idle;
  logic       beat_go;
  logic       beat_done;
  logic       last_loaded;

  assign accept = frame_valid_i & frame_ready_o;

  enc_frame_cfg i_enc_frame_cfg (
    .clk           (clk),
    .rstn          (rstn),
    .frame_valid_i (frame_valid_i),
    .frame_cfg_i   (frame_cfg_i),
    .idle_i        (idle),
    .frame_ready_o (frame_ready_o),
    .cfg_o         (cfg)
  );

  pipe_phase_fsm i_pipe_phase_fsm (
    .clk           (clk),
    .rstn          (rstn),
    .accept_i      (accept),
    .beat_done_i   (beat_done),
    .last_loaded_i (last_loaded),
    .phase_o       (),
    .stage_ena_o   (stage_ena),
    .beat_go_o     (beat_go),
    .idle_o        (idle),
    .frame_done_o  (frame_done_o)
  );

  done_collector i_done_collector (
    .clk         (clk),
    .rstn        (rstn),
    .cfg_i       (cfg),
    .stage_ena_i (stage_ena),
    .idle_i      (idle),
    .done_i      (eng_done_i),
    .beat_done_o (beat_done)
  );

  ctu_pos_chain i_ctu_pos_chain (
    .clk           (clk),
    .rstn          (rstn),
    .cfg_i         (cfg),
    .stage_ena_i   (stage_ena),
    .beat_go_i     (beat_go),
    .idle_i        (idle),
    .last_loaded_o (last_loaded),
    .start_o       (eng_start_o),
    .pos_s1_o      (pos_s1_o),
    .pos_s2_o      (pos_s2_o),
    .pos_rec_o     (pos_rec_o),
    .pos_db_o      (pos_db_o),
    .pos_ec_o      (pos_ec_o),
    .fetch_o       (fetch_o)
  );

endmodule

//--- testbench/tb_clk_gen.sv
/*
  testbench clock and reset
  - 4 ns clock, reset low for the first 4 cycles
*/
module tb_clk_gen (
  output logic clk_o,
  output logic rstn_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o  = 1'b0;
    rstn_o = 1'b0;
    repeat (4) @(posedge clk_o);
    rstn_o <= 1'b1;
  end

  always #2 clk_o = ~clk_o;

endmodule

//--- testbench/tb_enc_ctrl.sv
/*
  testbench of the encoder pipeline controller
  - engine and fetch responders with random done latency
  - start, position and fetch monitor
  - value check task and directed test tasks
*/
module tb_enc_ctrl import enc_ctrl_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic       clk;
  logic       rstn;
  logic       frame_valid;
  frame_cfg_t frame_cfg;
  logic       frame_ready;
  logic       frame_done;
  eng_done_t  eng_done = '0;
  eng_start_t eng_start;
  ctu_pos_t   pos_s1;
  ctu_pos_t   pos_s2;
  ctu_pos_t   pos_rec;
  ctu_pos_t   pos_db;
  ctu_pos_t   pos_ec;
  fetch_bus_t fetch;

  int errors = 0;
  int checks = 0;
  // responder countdowns and extra hold, indexed by done bit (fetch is bit 7)
  int cnt[8];
  int hold_cyc[8];
  // monitor state, positions indexed by start bit
  int pos_q[7][$];
  // fetch positions, 0 cur_luma, 1 cur_chroma, 2 db_load, 3 db_store
  int fetch_q[4][$];
  int beat_cnt;
  int done_cnt;
  int ref_bad;
  int me_bad;
  logic exp_inter;
  logic go_seen;

  tb_clk_gen i_tb_clk_gen (.clk_o(clk), .rstn_o(rstn));

  enc_ctrl_top i_enc_ctrl_top (
    .clk           (clk),
    .rstn          (rstn),
    .frame_valid_i (frame_valid),
    .frame_cfg_i   (frame_cfg),
    .frame_ready_o (frame_ready),
    .frame_done_o  (frame_done),
    .eng_done_i    (eng_done),
    .eng_start_o   (eng_start),
    .pos_s1_o      (pos_s1),
    .pos_s2_o      (pos_s2),
    .pos_rec_o     (pos_rec),
    .pos_db_o      (pos_db),
    .pos_ec_o      (pos_ec),
    .fetch_o       (fetch)
  );

  // --------------------------------------------------------------------------
  // responders: a done pulse 1 to 6 cycles after each start
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    logic [7:0] trig;
    logic [7:0] d;
    d    = '0;
    trig = {i_enc_ctrl_top.beat_go, eng_start};
    for (int i = 0; i < 8; i++) begin
      if (!rstn) begin
        cnt[i] = 0;
      end else begin
        if (cnt[i] == 1) d[i] = 1'b1;
        if (cnt[i] != 0) cnt[i] = cnt[i] - 1;
        if (trig[i]) begin
          cnt[i]      = 1 + int'($urandom % 6) + hold_cyc[i];
          hold_cyc[i] = 0;
        end
      end
    end
    eng_done <= eng_done_t'(d);
  end

  // position an engine works on, by start bit
  function automatic int stage_pos(input int i);
    case (i)
      6, 4:    return int'(pos_s1);
      5, 3:    return int'(pos_s2);
      2:       return int'(pos_rec);
      1:       return int'(pos_db);
      default: return int'(pos_ec);
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // monitor
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < 7; i++) begin
        if (eng_start[i]) pos_q[i].push_back(stage_pos(i));
      end
      if (eng_start.ime != (eng_start.prei & exp_inter)) me_bad++;
      if (eng_start.fme != (eng_start.posi & exp_inter)) me_bad++;
      if (frame_done) done_cnt++;
      // first cycle of a beat
      if (go_seen) begin
        beat_cnt++;
        if (fetch.cur_luma.en) fetch_q[0].push_back(int'(fetch.cur_luma.pos));
        if (fetch.cur_chroma.en) fetch_q[1].push_back(int'(fetch.cur_chroma.pos));
        if (fetch.db_load.en) fetch_q[2].push_back(int'(fetch.db_load.pos));
        if (fetch.db_store.en) fetch_q[3].push_back(int'(fetch.db_store.pos));
        if (fetch.cur_luma.en && fetch.cur_luma.with_ref != exp_inter) ref_bad++;
        if (fetch.cur_chroma.en && fetch.cur_chroma.with_ref != exp_inter) ref_bad++;
      end
      go_seen = i_enc_ctrl_top.beat_go;
    end else begin
      go_seen = 1'b0;
    end
  end

  task automatic check_val(input int got, input int exp, input string msg);
    checks++;
    if (got != exp) begin
      errors++;
      $display("** Error at %0t ns: %s, got %0d, expected %0d", $time, msg, got, exp);
    end
  endtask

  // element by element comparison of two position lists
  task automatic compare_queue(input int got[$], input int exp[$], input string what);
    check_val(got.size(), exp.size(), $sformatf("number of %s", what));
    for (int k = 0; k < got.size() && k < exp.size(); k++) begin
      check_val(got[k], exp[k], $sformatf("%s %0d", what, k));
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout: %s did not happen in time at %0t ns", what, $time);
  endtask

  task automatic clear_monitor(input logic inter);
    for (int i = 0; i < 7; i++) pos_q[i].delete();
    for (int j = 0; j < 4; j++) fetch_q[j].delete();
    beat_cnt  = 0;
    done_cnt  = 0;
    ref_bad   = 0;
    me_bad    = 0;
    exp_inter = inter;
  endtask

  // offer a command and wait for its acceptance
  task automatic send_frame(input enc_mode_e mode, input int w, input int h);
    int t;
    clear_monitor(mode == MODE_INTER);
    @(posedge clk);
    frame_valid      <= 1'b1;
    frame_cfg.mode   <= mode;
    frame_cfg.last_x <= ctu_x_t'(w - 1);
    frame_cfg.last_y <= ctu_y_t'(h - 1);
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!frame_ready && t < 50);
    frame_valid <= 1'b0;
    if (!frame_ready) report_timeout("frame command acceptance");
  endtask

  task automatic wait_frame_done();
    int t;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!frame_done && t < 3000);
    if (!frame_done) report_timeout("frame_done_o");
    repeat (4) @(posedge clk);
  endtask

  // compare what the monitor saw with the raster order of a w x h frame
  task automatic check_frame(input logic inter, input int w, input int h);
    int exp_pos[$];
    int exp_load[$];
    int exp_store[$];
    int n;
    int p;
    n = w * h;
    for (int y = 0; y < h; y++) begin
      for (int x = 0; x < w; x++) begin
        p = (x << CTU_Y_W) | y;
        exp_pos.push_back(p);
        // no top neighbour in row 0, no store in column 0
        if (y != 0) exp_load.push_back(p);
        if (x != 0) exp_store.push_back(p);
      end
    end
    for (int i = 0; i < 7; i++) begin
      if (!inter && (i == 4 || i == 3)) begin
        check_val(pos_q[i].size(), 0, $sformatf("starts of engine bit %0d in intra", i));
      end else begin
        check_val(pos_q[i].size(), n, $sformatf("starts of engine bit %0d", i));
        for (int k = 0; k < n && k < pos_q[i].size(); k++) begin
          check_val(pos_q[i][k], exp_pos[k], $sformatf("position %0d at engine bit %0d", k, i));
        end
      end
    end
    compare_queue(fetch_q[0], exp_pos, "cur_luma positions");
    compare_queue(fetch_q[1], exp_pos, "cur_chroma positions");
    compare_queue(fetch_q[2], exp_load, "db_load positions");
    compare_queue(fetch_q[3], exp_store, "db_store positions");
    check_val(done_cnt, 1, "frame_done_o pulses");
    check_val(beat_cnt, n + 5, "beats per frame");
    check_val(ref_bad, 0, "with_ref of current fetches");
    check_val(me_bad, 0, "motion estimation starts apart from pre-analysis");
    check_val(frame_ready, 1, "frame_ready_o after the frame");
  endtask

  task automatic run_frame(input enc_mode_e mode, input int w, input int h);
    send_frame(mode, w, h);
    wait_frame_done();
    check_frame(mode == MODE_INTER, w, h);
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic test_reset();
    check_val(int'(eng_start), 0, "start pulses after reset");
    check_val(fetch.cur_luma.en, 0, "cur_luma enable after reset");
    check_val(fetch.cur_chroma.en, 0, "cur_chroma enable after reset");
    check_val(fetch.db_load.en, 0, "db_load enable after reset");
    check_val(fetch.db_store.en, 0, "db_store enable after reset");
    check_val(frame_done, 0, "frame_done_o after reset");
    check_val(frame_ready, 1, "frame_ready_o after reset");
  endtask

  task automatic test_backpressure();
    int t;
    int stray;
    hold_cyc[2] = 20;
    send_frame(MODE_INTRA, 3, 2);
    // a second command while the frame runs
    frame_valid      <= 1'b1;
    frame_cfg.mode   <= MODE_INTER;
    frame_cfg.last_x <= ctu_x_t'(5);
    repeat (5) begin
      @(posedge clk);
      check_val(frame_ready, 0, "frame_ready_o while a frame runs");
    end
    frame_valid <= 1'b0;
    t = 0;
    while (!eng_start.rec && t < 500) begin
      @(posedge clk);
      t++;
    end
    if (!eng_start.rec) report_timeout("first rec start");
    t     = 0;
    stray = 0;
    do begin
      @(posedge clk);
      t++;
      if (eng_start != '0) stray++;
    end while (!eng_done.rec && t < 100);
    if (!eng_done.rec) report_timeout("held rec done");
    check_val(stray, 0, "start pulses while rec is held");
    wait_frame_done();
    check_frame(1'b0, 3, 2);
    run_frame(MODE_INTER, 2, 3);
  endtask

  initial begin
    int t;
    void'($urandom(9511));
    frame_valid = 1'b0;
    frame_cfg   = '0;
    exp_inter   = 1'b0;
    go_seen     = 1'b0;
    for (int i = 0; i < 8; i++) hold_cyc[i] = 0;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!rstn && t < 20);
    if (!rstn) report_timeout("reset release");
    @(posedge clk);
    test_reset();
    run_frame(MODE_INTRA, 3, 2);
    run_frame(MODE_INTER, 4, 2);
    run_frame(MODE_INTRA, 3, 3);
    test_backpressure();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
source/enc_ctrl_pkg.sv
source/enc_frame_cfg.sv
source/pipe_phase_fsm.sv
source/done_collector.sv
source/ctu_pos_chain.sv
source/enc_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/tb_enc_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_enc_ctrl \
  -f vlog.f \
  -o sim_enc_ctrl

out="$(./obj_dir/sim_enc_ctrl)"
echo "$out"

if grep -qx "ALL CHECKS PASSED" <<< "$out"; then
  exit 0
fi
exit 1
